// ==== insn_ctrl_testdata.hex ====
// columns: if_insn, flags {wbforw_valid, extend_flush, pc_we, flushpipe, wb_frz, ex_frz, id_frz}
// then expected simm, alu_op, rfwb_op, illegal, sel_imm for that instruction
9C618005 00 FFFF8005 00 1 0 1
A8831234 40 00001234 04 1 0 1
E0A41800 40 00001800 00 1 0 0
E0C52806 00 00002806 06 1 1 0
E022180A 00 0000180A 0A 1 1 0
FC000000 00 00000000 14 0 1 1
04000010 00 00000010 14 7 0 1
48003800 40 00003800 14 7 0 0
8441FFFC 40 FFFFFFFC 14 3 0 1
D4011008 00 00000008 14 0 0 0
DFE327F0 40 FFFFFFF0 14 0 0 0
C2011005 00 00008005 14 0 0 0
B4E10011 00 00000011 14 5 0 0
20000001 00 00000001 14 0 0 0
21000000 00 00000000 14 0 0 0
BC64FFFF 00 FFFFFFFF 11 0 0 1
1900ABCD 01 0000ABCD 10 1 0 1
1900ABCD 00 0000ABCD 10 1 0 1
A52800FF 02 000000FF 03 1 0 1
AD498000 44 FFFF8000 05 1 0 1
A16A0007 08 00000007 01 1 0 1
918B0080 10 00000080 14 3 0 1
95AC0002 20 00000002 14 3 0 1
15410000 00 00000000 14 0 0 0
D80D2800 03 00000000 14 0 0 0
D80D2800 00 00000000 14 0 0 0
00000100 40 00000100 14 0 0 1
10000004 00 00000004 14 0 0 1
44004800 40 00004800 14 0 0 0
24000000 00 00000000 14 0 0 0

// ==== filelist.f ====
+incdir+.
ctrl_pkg.sv
fetch_latch.sv
id_decode.sv
ex_stage.sv
wb_forward_stage.sv
insn_ctrl_top.sv
insn_ctrl_sva.sv
insn_ctrl_checker.sv
tb_insn_ctrl.sv

// ==== tb_insn_ctrl.sv ====
// testbench for the instruction-control pipeline, vectors come from the hex data file
// the checker compares outputs, bound assertions watch flush and bubbles
`timescale 1ns/1ps
`include "ctrl_params.svh"

module tb_insn_ctrl;
	import ctrl_pkg::*;

	localparam int NVEC  = 30;
	localparam int COLS  = 7;
	localparam int LIMIT = NVEC * 3 + 50;

	logic [31:0] vec_mem [0:NVEC*COLS-1];
	int          cycles = 0;

	logic                   clk;
	logic                   reset;
	logic [`INSN_W-1:0]     if_insn;
	logic                   id_freeze, ex_freeze, wb_freeze;
	logic                   except_flushpipe, pc_we, extend_flush, wbforw_valid;
	logic [`INSN_W-1:0]     exp_simm;
	logic [4:0]             exp_alu;
	logic [2:0]             exp_rfwb;
	logic                   exp_illegal, exp_sel_imm;
	logic [`INSN_W-1:0]     id_insn, ex_insn, wb_insn, id_simm, ex_simm;
	lsu_op_t                id_lsu_op;
	alu_op_t                alu_op;
	comp_op_t               comp_op;
	rfwb_op_t               rfwb_op;
	logic [`REG_ADDR_W-1:0] rf_addrw, rf_addra, rf_addrb;
	logic                   rf_rda, rf_rdb;
	sel_t                   sel_a, sel_b;
	logic                   except_illegal, sig_syscall, sig_trap;

	insn_ctrl_top insn_ctrl_top_i (.*);

	insn_ctrl_checker checker_i (.*);

	bind insn_ctrl_top insn_ctrl_sva insn_ctrl_sva_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic set_flags(logic [6:0] flags);
		{wbforw_valid, extend_flush, pc_we, except_flushpipe,
			wb_freeze, ex_freeze, id_freeze} = flags;
	endtask

	// idle word and its decode
	task automatic drive_nop(logic [6:0] flags);
		if_insn     = `NOP_INSN;
		exp_simm    = '0;
		exp_alu     = ALU_NOP;
		exp_rfwb    = RFWB_NOP;
		exp_illegal = 1'b0;
		exp_sel_imm = 1'b0;
		set_flags(flags);
	endtask

	task automatic drive_vector(int idx);
		if_insn     = vec_mem[idx*COLS];
		exp_simm    = vec_mem[idx*COLS+2];
		exp_alu     = vec_mem[idx*COLS+3][4:0];
		exp_rfwb    = vec_mem[idx*COLS+4][2:0];
		exp_illegal = vec_mem[idx*COLS+5][0];
		exp_sel_imm = vec_mem[idx*COLS+6][0];
		set_flags(vec_mem[idx*COLS+1][6:0]);
	endtask

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(46262));
		reset = 1'b1;
		drive_nop(7'h00);
		$readmemh("insn_ctrl_testdata.hex", vec_mem);
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		for (int i = 0; i < NVEC; i++) begin
			drive_vector(i);
			@(posedge clk);
			#1;
		end
		// random freeze levels on an idle stream
		repeat (20) begin
			drive_nop({1'($urandom_range(1)), 3'b000, 3'($urandom_range(7))});
			@(posedge clk);
			#1;
		end
		drive_nop(7'h00);
		repeat (4) @(posedge clk);
		#1;
		$display("run complete, %0d compare errors, %0d assertion failures",
			checker_i.errors, insn_ctrl_top_i.insn_ctrl_sva_i.fail_count);
		if (checker_i.errors == 0 && insn_ctrl_top_i.insn_ctrl_sva_i.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== insn_ctrl_checker.sv ====
// reference ID/EX/WB pipeline that compares every DUT output each cycle
// sits beside the DUT in the testbench and counts mismatches
`timescale 1ns/1ps
`include "ctrl_params.svh"

module insn_ctrl_checker (
	input logic                   clk,
	input logic                   reset,
	input logic [`INSN_W-1:0]     if_insn,
	input logic                   id_freeze,
	input logic                   ex_freeze,
	input logic                   wb_freeze,
	input logic                   except_flushpipe,
	input logic                   pc_we,
	input logic                   extend_flush,
	input logic                   wbforw_valid,
	input logic [`INSN_W-1:0]     exp_simm,
	input logic [4:0]             exp_alu,
	input logic [2:0]             exp_rfwb,
	input logic                   exp_illegal,
	input logic                   exp_sel_imm,
	input logic [`INSN_W-1:0]     id_insn,
	input logic [`INSN_W-1:0]     ex_insn,
	input logic [`INSN_W-1:0]     wb_insn,
	input logic [`INSN_W-1:0]     id_simm,
	input logic [`INSN_W-1:0]     ex_simm,
	input ctrl_pkg::lsu_op_t      id_lsu_op,
	input ctrl_pkg::alu_op_t      alu_op,
	input ctrl_pkg::comp_op_t     comp_op,
	input ctrl_pkg::rfwb_op_t     rfwb_op,
	input logic [`REG_ADDR_W-1:0] rf_addrw,
	input logic [`REG_ADDR_W-1:0] rf_addra,
	input logic [`REG_ADDR_W-1:0] rf_addrb,
	input logic                   rf_rda,
	input logic                   rf_rdb,
	input ctrl_pkg::sel_t         sel_a,
	input ctrl_pkg::sel_t         sel_b,
	input logic                   except_illegal,
	input logic                   sig_syscall,
	input logic                   sig_trap
);
	import ctrl_pkg::*;

	int errors = 0;

	logic [31:0] r_id_insn, r_id_simm, r_ex_insn, r_ex_simm, r_wb_insn;
	logic [4:0]  r_id_alu, r_ex_alu, r_ex_addrw, r_wb_addrw;
	logic [3:0]  r_ex_comp;
	logic [2:0]  r_id_rfwb, r_ex_rfwb;
	logic        r_id_ill, r_ex_ill, r_sel_imm;
	logic        flush, bubble;

	assign flush  = except_flushpipe | pc_we | extend_flush;
	assign bubble = (id_freeze && !ex_freeze) || flush;

	function automatic logic [3:0] lsu_for(logic [31:0] insn);
		case (insn[31:26])
			OP_LWZ:  return LSU_LWZ;
			OP_LWS:  return LSU_LWS;
			OP_LBZ:  return LSU_LBZ;
			OP_LBS:  return LSU_LBS;
			OP_LHZ:  return LSU_LHZ;
			OP_LHS:  return LSU_LHS;
			OP_SW:   return LSU_SW;
			OP_SB:   return LSU_SB;
			OP_SH:   return LSU_SH;
			default: return LSU_NOP;
		endcase
	endfunction

	// EX result first, then WB, then the register file
	function automatic logic [1:0] sel_for(logic [4:0] src, logic imm);
		if (imm)
			return SEL_IMM;
		if (src == r_ex_addrw && r_ex_rfwb[0])
			return SEL_EX_FORW;
		if (src == r_wb_addrw && wbforw_valid)
			return SEL_WB_FORW;
		return SEL_RF;
	endfunction

	task automatic compare(string name, logic [31:0] exp_val, logic [31:0] act_val);
		if (act_val !== exp_val) begin
			$display("FAILED %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// reference pipeline
	////////////////////////////////////////
	always @(posedge clk) begin
		if (!ex_freeze)
			r_ex_simm <= r_id_simm;
		if (!wb_freeze)
			r_wb_addrw <= r_ex_addrw;
		if (reset) begin
			r_id_insn <= `NOP_INSN;
			r_id_simm <= '0;
			r_id_alu  <= ALU_NOP;
			r_id_rfwb <= RFWB_NOP;
			r_id_ill  <= 1'b0;
			r_sel_imm <= 1'b0;
		end else if (flush) begin
			r_id_insn <= `NOP_INSN;
			r_id_simm <= '0;
			r_id_alu  <= ALU_NOP;
			r_id_rfwb <= RFWB_NOP;
			r_id_ill  <= 1'b0;
		end else if (!id_freeze) begin
			r_id_insn <= if_insn;
			r_id_simm <= exp_simm;
			r_id_alu  <= exp_alu;
			r_id_rfwb <= exp_rfwb;
			r_id_ill  <= exp_illegal;
		end
		if (!reset && !id_freeze)
			r_sel_imm <= exp_sel_imm;
		if (reset || bubble) begin
			r_ex_insn  <= `NOP_INSN;
			r_ex_alu   <= ALU_NOP;
			r_ex_rfwb  <= RFWB_NOP;
			r_ex_addrw <= '0;
			r_ex_comp  <= '0;
			r_ex_ill   <= 1'b0;
		end else if (!ex_freeze) begin
			r_ex_insn  <= r_id_insn;
			r_ex_alu   <= r_id_alu;
			r_ex_rfwb  <= r_id_rfwb;
			r_ex_addrw <= (r_id_insn[31:26] inside {OP_JAL, OP_JALR}) ?
				`LINK_REG : r_id_insn[25:21];
			r_ex_comp  <= r_id_insn[24:21];
			r_ex_ill   <= r_id_ill;
		end
		if (reset)
			r_wb_insn <= `NOP_INSN;
		else if (!wb_freeze)
			r_wb_insn <= r_ex_insn;
	end

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			compare("id_insn", r_id_insn, id_insn);
			compare("ex_insn", r_ex_insn, ex_insn);
			compare("wb_insn", r_wb_insn, wb_insn);
			compare("id_simm", r_id_simm, id_simm);
			compare("ex_simm", r_ex_simm, ex_simm);
			compare("id_lsu_op", lsu_for(r_id_insn), id_lsu_op);
			compare("alu_op", r_ex_alu, alu_op);
			compare("rfwb_op", r_ex_rfwb, rfwb_op);
			compare("rf_addrw", r_ex_addrw, rf_addrw);
			compare("comp_op", r_ex_comp, comp_op);
			compare("except_illegal", r_ex_ill, except_illegal);
			compare("sig_syscall", r_ex_insn[31:23] == {6'h08, 3'b000}, sig_syscall);
			compare("sig_trap", r_ex_insn[31:23] == {6'h08, 3'b010}, sig_trap);
			compare("rf_addra", if_insn[20:16], rf_addra);
			compare("rf_addrb", if_insn[15:11], rf_addrb);
			compare("rf_rda", if_insn[31], rf_rda);
			compare("rf_rdb", if_insn[30], rf_rdb);
			compare("sel_a", sel_for(r_id_insn[20:16], 1'b0), sel_a);
			compare("sel_b", sel_for(r_id_insn[15:11], r_sel_imm), sel_b);
		end
	end

endmodule

// ==== insn_ctrl_sva.sv ====
// concurrent checks on flush and bubble behavior of the ID and EX stages
// bound into insn_ctrl_top from the testbench
`timescale 1ns/1ps
`include "ctrl_params.svh"

module insn_ctrl_sva (
	input logic              clk,
	input logic              reset,
	input logic              pipe_flush,
	input logic              id_freeze,
	input logic              ex_freeze,
	input logic [`INSN_W-1:0] id_insn,
	input logic [`INSN_W-1:0] ex_insn,
	input logic              except_illegal,
	input logic              sig_syscall,
	input logic              sig_trap
);
	logic bubble;
	int   fail_count = 0;

	assign bubble = pipe_flush || (id_freeze && !ex_freeze);

	a_flush_id: assert property (@(posedge clk) disable iff (reset)
		pipe_flush |=> id_insn == `NOP_INSN)
		else begin
			fail_count++;
			$error("flush did not load the NOP word into ID");
		end

	a_bubble_ex: assert property (@(posedge clk) disable iff (reset)
		bubble |=> ex_insn == `NOP_INSN)
		else begin
			fail_count++;
			$error("EX did not take a bubble");
		end

	// a bubble carries no exception or strobe
	a_bubble_quiet: assert property (@(posedge clk) disable iff (reset)
		bubble |=> !except_illegal && !sig_syscall && !sig_trap)
		else begin
			fail_count++;
			$error("exception or strobe active after a bubble");
		end

endmodule

// ==== insn_ctrl_top.sv ====
// top of the instruction-control pipeline, IF/ID latch through WB forwarding
// stages are joined by wires only
`timescale 1ns/1ps
`include "ctrl_params.svh"

module insn_ctrl_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`INSN_W-1:0]     if_insn,
	input  logic                   id_freeze,
	input  logic                   ex_freeze,
	input  logic                   wb_freeze,
	input  logic                   except_flushpipe,
	input  logic                   pc_we,
	input  logic                   extend_flush,
	input  logic                   wbforw_valid,
	output logic [`INSN_W-1:0]     id_insn,
	output logic [`INSN_W-1:0]     ex_insn,
	output logic [`INSN_W-1:0]     wb_insn,
	output logic [`INSN_W-1:0]     id_simm,
	output logic [`INSN_W-1:0]     ex_simm,
	output ctrl_pkg::lsu_op_t      id_lsu_op,
	output ctrl_pkg::alu_op_t      alu_op,
	output ctrl_pkg::comp_op_t     comp_op,
	output ctrl_pkg::rfwb_op_t     rfwb_op,
	output logic [`REG_ADDR_W-1:0] rf_addrw,
	output logic [`REG_ADDR_W-1:0] rf_addra,
	output logic [`REG_ADDR_W-1:0] rf_addrb,
	output logic                   rf_rda,
	output logic                   rf_rdb,
	output ctrl_pkg::sel_t         sel_a,
	output ctrl_pkg::sel_t         sel_b,
	output logic                   except_illegal,
	output logic                   sig_syscall,
	output logic                   sig_trap
);
	import ctrl_pkg::*;

	logic                   sel_imm;
	logic                   pipe_flush;
	alu_op_t                next_alu_op;
	rfwb_op_t               next_rfwb_op;
	logic [`REG_ADDR_W-1:0] next_rf_addrw;
	comp_op_t               next_comp_op;
	logic                   next_illegal;
	logic                   next_syscall;
	logic                   next_trap;

	fetch_latch fetch_latch_i (
		.clk              (clk),
		.reset            (reset),
		.if_insn          (if_insn),
		.id_freeze        (id_freeze),
		.except_flushpipe (except_flushpipe),
		.pc_we            (pc_we),
		.extend_flush     (extend_flush),
		.id_insn          (id_insn),
		.sel_imm          (sel_imm),
		.pipe_flush       (pipe_flush),
		.rf_addra         (rf_addra),
		.rf_addrb         (rf_addrb),
		.rf_rda           (rf_rda),
		.rf_rdb           (rf_rdb)
	);

	id_decode id_decode_i (
		.id_insn       (id_insn),
		.id_simm       (id_simm),
		.id_lsu_op     (id_lsu_op),
		.next_alu_op   (next_alu_op),
		.next_rfwb_op  (next_rfwb_op),
		.next_rf_addrw (next_rf_addrw),
		.next_comp_op  (next_comp_op),
		.next_illegal  (next_illegal),
		.next_syscall  (next_syscall),
		.next_trap     (next_trap)
	);

	ex_stage ex_stage_i (
		.clk            (clk),
		.reset          (reset),
		.ex_freeze      (ex_freeze),
		.id_freeze      (id_freeze),
		.pipe_flush     (pipe_flush),
		.id_insn        (id_insn),
		.id_simm        (id_simm),
		.next_alu_op    (next_alu_op),
		.next_rfwb_op   (next_rfwb_op),
		.next_rf_addrw  (next_rf_addrw),
		.next_comp_op   (next_comp_op),
		.next_illegal   (next_illegal),
		.next_syscall   (next_syscall),
		.next_trap      (next_trap),
		.ex_insn        (ex_insn),
		.ex_simm        (ex_simm),
		.alu_op         (alu_op),
		.comp_op        (comp_op),
		.rfwb_op        (rfwb_op),
		.rf_addrw       (rf_addrw),
		.except_illegal (except_illegal),
		.sig_syscall    (sig_syscall),
		.sig_trap       (sig_trap)
	);

	wb_forward_stage wb_forward_stage_i (
		.clk          (clk),
		.reset        (reset),
		.wb_freeze    (wb_freeze),
		.wbforw_valid (wbforw_valid),
		.ex_insn      (ex_insn),
		.rf_addrw     (rf_addrw),
		.rfwb_op      (rfwb_op),
		.id_insn      (id_insn),
		.sel_imm      (sel_imm),
		.wb_insn      (wb_insn),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

endmodule

// ==== wb_forward_stage.sv ====
// WB stage latch for the retiring instruction and its write address
// generates the operand-forwarding selects for the instruction in ID
`timescale 1ns/1ps
`include "ctrl_params.svh"

module wb_forward_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   wb_freeze,
	input  logic                   wbforw_valid,
	input  logic [`INSN_W-1:0]     ex_insn,
	input  logic [`REG_ADDR_W-1:0] rf_addrw,
	input  ctrl_pkg::rfwb_op_t     rfwb_op,
	input  logic [`INSN_W-1:0]     id_insn,
	input  logic                   sel_imm,
	output logic [`INSN_W-1:0]     wb_insn,
	output ctrl_pkg::sel_t         sel_a,
	output ctrl_pkg::sel_t         sel_b
);
	import ctrl_pkg::*;

	logic [`REG_ADDR_W-1:0] wb_rfaddrw;
	logic                   ex_writes;

	assign ex_writes = rfwb_op[0];

	// flush leaves WB alone
	always_ff @(posedge clk) begin
		if (reset)
			wb_insn <= `NOP_INSN;
		else if (!wb_freeze)
			wb_insn <= ex_insn;
	end

	always_ff @(posedge clk) begin
		if (!wb_freeze)
			wb_rfaddrw <= rf_addrw;
	end

	////////////////////////////////////////
	// forwarding, EX result before WB
	////////////////////////////////////////
	always_comb begin
		if (id_insn[20:16] == rf_addrw && ex_writes)
			sel_a = SEL_EX_FORW;
		else if (id_insn[20:16] == wb_rfaddrw && wbforw_valid)
			sel_a = SEL_WB_FORW;
		else
			sel_a = SEL_RF;
	end

	always_comb begin
		if (sel_imm)
			sel_b = SEL_IMM;
		else if (id_insn[15:11] == rf_addrw && ex_writes)
			sel_b = SEL_EX_FORW;
		else if (id_insn[15:11] == wb_rfaddrw && wbforw_valid)
			sel_b = SEL_WB_FORW;
		else
			sel_b = SEL_RF;
	end

endmodule

// ==== ex_stage.sv ====
// EX stage registers for the instruction and its decoded controls
// a bubble goes in when ID freezes under a running EX or on any flush
`timescale 1ns/1ps
`include "ctrl_params.svh"

module ex_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ex_freeze,
	input  logic                   id_freeze,
	input  logic                   pipe_flush,
	input  logic [`INSN_W-1:0]     id_insn,
	input  logic [`INSN_W-1:0]     id_simm,
	input  ctrl_pkg::alu_op_t      next_alu_op,
	input  ctrl_pkg::rfwb_op_t     next_rfwb_op,
	input  logic [`REG_ADDR_W-1:0] next_rf_addrw,
	input  ctrl_pkg::comp_op_t     next_comp_op,
	input  logic                   next_illegal,
	input  logic                   next_syscall,
	input  logic                   next_trap,
	output logic [`INSN_W-1:0]     ex_insn,
	output logic [`INSN_W-1:0]     ex_simm,
	output ctrl_pkg::alu_op_t      alu_op,
	output ctrl_pkg::comp_op_t     comp_op,
	output ctrl_pkg::rfwb_op_t     rfwb_op,
	output logic [`REG_ADDR_W-1:0] rf_addrw,
	output logic                   except_illegal,
	output logic                   sig_syscall,
	output logic                   sig_trap
);
	import ctrl_pkg::*;

	logic bubble;

	// flush overrides an EX freeze
	assign bubble = (!ex_freeze && id_freeze) || pipe_flush;

	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			ex_insn        <= `NOP_INSN;
			alu_op         <= ALU_NOP;
			comp_op        <= '0;
			rfwb_op        <= RFWB_NOP;
			rf_addrw       <= '0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (!ex_freeze) begin
			ex_insn        <= id_insn;
			alu_op         <= next_alu_op;
			comp_op        <= next_comp_op;
			rfwb_op        <= next_rfwb_op;
			rf_addrw       <= next_rf_addrw;
			except_illegal <= next_illegal;
			sig_syscall    <= next_syscall;
			sig_trap       <= next_trap;
		end
	end

	// immediate ignores bubbles, only ex_freeze holds it
	always_ff @(posedge clk) begin
		if (!ex_freeze)
			ex_simm <= id_simm;
	end

endmodule

// ==== id_decode.sv ====
// combinational ID decode of immediate, load/store operation and EX controls
// every output follows id_insn in the same cycle
`timescale 1ns/1ps
`include "ctrl_params.svh"

module id_decode (
	input  logic [`INSN_W-1:0]     id_insn,
	output logic [`INSN_W-1:0]     id_simm,
	output ctrl_pkg::lsu_op_t      id_lsu_op,
	output ctrl_pkg::alu_op_t      next_alu_op,
	output ctrl_pkg::rfwb_op_t     next_rfwb_op,
	output logic [`REG_ADDR_W-1:0] next_rf_addrw,
	output ctrl_pkg::comp_op_t     next_comp_op,
	output logic                   next_illegal,
	output logic                   next_syscall,
	output logic                   next_trap
);
	import ctrl_pkg::*;

	opcode_t id_opcode;
	alu_op_t alu_func;
	logic    alu_muldiv;

	assign id_opcode = opcode_t'(id_insn[31:26]);
	assign alu_func  = alu_op_t'(id_insn[4:0]);

	// no multiplier or divider in this core
	assign alu_muldiv = alu_func inside {ALU_MUL, ALU_MULU, ALU_DIV, ALU_DIVU};

	////////////////////////////////////////
	// immediate extension
	////////////////////////////////////////
	always_comb begin
		case (id_opcode)
			OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// split immediate around the rb field
			OP_MTSPR:
				id_simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			OP_SW, OP_SB, OP_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'b0, id_insn[15:0]};
		endcase
	end

	// load/store operation for the lsu
	always_comb begin
		case (id_opcode)
			OP_LWZ:  id_lsu_op = LSU_LWZ;
			OP_LWS:  id_lsu_op = LSU_LWS;
			OP_LBZ:  id_lsu_op = LSU_LBZ;
			OP_LBS:  id_lsu_op = LSU_LBS;
			OP_LHZ:  id_lsu_op = LSU_LHZ;
			OP_LHS:  id_lsu_op = LSU_LHS;
			OP_SW:   id_lsu_op = LSU_SW;
			OP_SB:   id_lsu_op = LSU_SB;
			OP_SH:   id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	////////////////////////////////////////
	// alu, write-back and legality
	////////////////////////////////////////
	always_comb begin
		next_alu_op  = ALU_NOP;
		next_rfwb_op = RFWB_NOP;
		next_illegal = 1'b0;
		case (id_opcode)
			OP_JAL, OP_JALR:
				next_rfwb_op = RFWB_LR;
			OP_MOVHI: begin
				next_alu_op  = ALU_MOVHI;
				next_rfwb_op = RFWB_ALU;
			end
			OP_MFSPR:
				next_rfwb_op = RFWB_SPRS;
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				next_rfwb_op = RFWB_LSU;
			OP_ADDI: begin
				next_alu_op  = ALU_ADD;
				next_rfwb_op = RFWB_ALU;
			end
			OP_ADDIC: begin
				next_alu_op  = ALU_ADDC;
				next_rfwb_op = RFWB_ALU;
			end
			OP_ANDI: begin
				next_alu_op  = ALU_AND;
				next_rfwb_op = RFWB_ALU;
			end
			OP_ORI: begin
				next_alu_op  = ALU_OR;
				next_rfwb_op = RFWB_ALU;
			end
			OP_XORI: begin
				next_alu_op  = ALU_XOR;
				next_rfwb_op = RFWB_ALU;
			end
			OP_SFXXI, OP_SFXX:
				next_alu_op = ALU_COMP;
			// register form takes the low four function bits
			OP_ALU: begin
				next_alu_op  = alu_op_t'({1'b0, id_insn[3:0]});
				next_rfwb_op = RFWB_ALU;
				next_illegal = alu_muldiv;
			end
			OP_J, OP_BNF, OP_BF, OP_JR, OP_NOP, OP_RFE, OP_XSYNC,
			OP_MTSPR, OP_SW, OP_SB, OP_SH: begin
				next_illegal = 1'b0;
			end
			default:
				next_illegal = 1'b1;
		endcase
	end

	// jal and jalr always write the link register
	assign next_rf_addrw = (id_opcode == OP_JAL || id_opcode == OP_JALR) ?
		`LINK_REG : id_insn[25:21];

	assign next_comp_op = id_insn[24:21];

	assign next_syscall = (id_insn[31:23] == {OP_XSYNC, `SYS_SUBOP});
	assign next_trap    = (id_insn[31:23] == {OP_XSYNC, `TRAP_SUBOP});

endmodule

// ==== fetch_latch.sv ====
// IF/ID stage, latches the fetched instruction and pre-decodes immediate use
// also presents the register file read addresses straight from fetch
`timescale 1ns/1ps
`include "ctrl_params.svh"

module fetch_latch (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`INSN_W-1:0]     if_insn,
	input  logic                   id_freeze,
	input  logic                   except_flushpipe,
	input  logic                   pc_we,
	input  logic                   extend_flush,
	output logic [`INSN_W-1:0]     id_insn,
	output logic                   sel_imm,
	output logic                   pipe_flush,
	output logic [`REG_ADDR_W-1:0] rf_addra,
	output logic [`REG_ADDR_W-1:0] rf_addrb,
	output logic                   rf_rda,
	output logic                   rf_rdb
);
	import ctrl_pkg::*;

	opcode_t if_opcode;
	logic    if_uses_imm;

	assign if_opcode = opcode_t'(if_insn[31:26]);

	// all flush sources hit every stage alike
	assign pipe_flush = except_flushpipe | pc_we | extend_flush;

	// read ports come straight off the fetched word
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	// operand b from the immediate unless register form
	always_comb begin
		case (if_opcode)
			OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP:
				if_uses_imm = 1'b0;
			default:
				if_uses_imm = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			id_insn <= `NOP_INSN;
			sel_imm <= 1'b0;
		end else begin
			// flush wins over freeze for the instruction latch
			if (pipe_flush)
				id_insn <= `NOP_INSN;
			else if (!id_freeze)
				id_insn <= if_insn;
			if (!id_freeze)
				sel_imm <= if_uses_imm;
		end
	end

endmodule

// ==== ctrl_pkg.sv ====
// opcode, operation and operand-select types of the instruction-control pipeline
// imported by every stage that decodes or forwards
package ctrl_pkg;

	// major opcode in bits 31:26
	typedef enum logic [5:0] {
		OP_J     = 6'h00,
		OP_JAL   = 6'h01,
		OP_BNF   = 6'h03,
		OP_BF    = 6'h04,
		OP_NOP   = 6'h05,
		OP_MOVHI = 6'h06,
		OP_XSYNC = 6'h08,
		OP_RFE   = 6'h09,
		OP_JR    = 6'h11,
		OP_JALR  = 6'h12,
		OP_LWZ   = 6'h21,
		OP_LWS   = 6'h22,
		OP_LBZ   = 6'h23,
		OP_LBS   = 6'h24,
		OP_LHZ   = 6'h25,
		OP_LHS   = 6'h26,
		OP_ADDI  = 6'h27,
		OP_ADDIC = 6'h28,
		OP_ANDI  = 6'h29,
		OP_ORI   = 6'h2a,
		OP_XORI  = 6'h2b,
		OP_MFSPR = 6'h2d,
		OP_SFXXI = 6'h2f,
		OP_MTSPR = 6'h30,
		OP_SW    = 6'h35,
		OP_SB    = 6'h36,
		OP_SH    = 6'h37,
		OP_ALU   = 6'h38,
		OP_SFXX  = 6'h39
	} opcode_t;

	// alu operation, low codes match the alu function field
	typedef enum logic [4:0] {
		ALU_ADD   = 5'h00,
		ALU_ADDC  = 5'h01,
		ALU_AND   = 5'h03,
		ALU_OR    = 5'h04,
		ALU_XOR   = 5'h05,
		ALU_MUL   = 5'h06,
		ALU_DIV   = 5'h09,
		ALU_DIVU  = 5'h0a,
		ALU_MULU  = 5'h0b,
		ALU_MOVHI = 5'h10,
		ALU_COMP  = 5'h11,
		ALU_NOP   = 5'h14
	} alu_op_t;

	// top two bits pick the source, bit 0 writes the register file
	typedef enum logic [2:0] {
		RFWB_NOP  = 3'b000,
		RFWB_ALU  = 3'b001,
		RFWB_LSU  = 3'b011,
		RFWB_SPRS = 3'b101,
		RFWB_LR   = 3'b111
	} rfwb_op_t;

	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0010,
		LSU_LBS = 4'b0011,
		LSU_LHZ = 4'b0100,
		LSU_LHS = 4'b0101,
		LSU_LWZ = 4'b0110,
		LSU_LWS = 4'b0111,
		LSU_SB  = 4'b1010,
		LSU_SH  = 4'b1100,
		LSU_SW  = 4'b1110
	} lsu_op_t;

	// operand source for the alu inputs
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_t;

	// compare condition straight from bits 24:21
	typedef logic [3:0] comp_op_t;

endpackage

// ==== ctrl_params.svh ====
// widths and constants shared by the instruction-control pipeline
// include in any stage that sizes ports or loads the bubble word
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction word and immediate width
`define INSN_W 32

// register file address width
`define REG_ADDR_W 5

// link register written by jal and jalr
`define LINK_REG 5'd9

// canonical bubble, a nop opcode with bit 16 set
`define NOP_INSN 32'h1541_0000

////////////////////////////////////////
// xsync sub-operations in bits 25:23
////////////////////////////////////////
`define SYS_SUBOP 3'b000
`define TRAP_SUBOP 3'b010

`endif
